// ==== hw/rv_ctl_params.svh ====
`ifndef RV_CTL_PARAMS_SVH
`define RV_CTL_PARAMS_SVH

// Instruction word
`define RV_XLEN  32

// Opcode and function fields
`define RV_OPC_W 7
`define RV_F3_W  3
`define RV_F7_W  7

// ALU select
`define RV_ALU_W 4

// Immediate format select
`define RV_IMM_W 4

// Writeback source select
`define RV_WB_W  2

`endif

// ==== hw/rv_ctl_pkg.sv ====
`default_nettype none

`include "rv_ctl_params.svh"

package rv_ctl_pkg;

    typedef enum logic [`RV_OPC_W-1:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [`RV_ALU_W-1:0] {
        ALU_AND    = 4'b0000,
        ALU_OR     = 4'b0001,
        ALU_ADD    = 4'b0010,
        ALU_SUB    = 4'b0011,
        ALU_SLT    = 4'b0100,
        ALU_PASS_B = 4'b0101,
        ALU_SLTU   = 4'b0110,
        ALU_SLL    = 4'b1000,
        ALU_XOR    = 4'b1001,
        ALU_SRL    = 4'b1100,
        ALU_SRA    = 4'b1101
    } alu_op_e;

    typedef enum logic [`RV_IMM_W-1:0] {
        IMM_R = 4'd0,
        IMM_I = 4'd1,
        IMM_S = 4'd2,
        IMM_B = 4'd3,
        IMM_U = 4'd4,
        IMM_J = 4'd5
    } imm_sel_e;

    typedef enum logic [`RV_WB_W-1:0] {
        WB_MEM = 2'd0,
        WB_ALU = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    typedef struct packed {
        logic [`RV_F7_W-1:0]  funct7;
        logic [4:0]           rs2;
        logic [4:0]           rs1;
        logic [`RV_F3_W-1:0]  funct3;
        logic [4:0]           rd;
        logic [`RV_OPC_W-1:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]          imm12;
        logic [4:0]           rs1;
        logic [`RV_F3_W-1:0]  funct3;
        logic [4:0]           rd;
        logic [`RV_OPC_W-1:0] opcode;
    } i_view_t;

    // Same 32-bit word, seen as register form or immediate form
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instr_u;

    typedef struct packed {
        logic     a_sel;
        logic     b_sel;
        alu_op_e  alu_sel;
        logic     mem_wr;
        logic     reg_wen;
        imm_sel_e imm_sel;
        logic     br_un;
        logic     pc_sel;
        wb_sel_e  wb_sel;
    } ctl_word_t;

    // pc_sel here only marks an unconditional jump
    typedef struct packed {
        ctl_word_t ctl;
        logic      is_branch;
        logic      illegal;
    } dec_out_t;

    typedef struct packed {
        logic taken;
        logic br_un;
        logic f3_ok;
    } br_out_t;

endpackage

`default_nettype wire

// ==== hw/op_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_ctl_params.svh"

module op_decoder (
    input  wire rv_ctl_pkg::instr_u instr,
    output rv_ctl_pkg::dec_out_t    dec
);
    import rv_ctl_pkg::*;

    localparam logic [`RV_F7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [`RV_F7_W-1:0] F7_ALT  = 7'b0100000;

    logic [`RV_F3_W-1:0] funct3;
    logic                f7_base;
    logic                f7_alt;
    logic                bad;

    assign funct3  = instr.r_view.funct3;
    assign f7_base = (instr.r_view.funct7 == F7_BASE);
    assign f7_alt  = (instr.r_view.funct7 == F7_ALT);

    // OP and OP-IMM share one funct3 map; SUB only exists in register form
    function automatic alu_op_e alu_of(
        input logic [`RV_F3_W-1:0] f3,
        input logic                alt,
        input logic                reg_form
    );
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && reg_form) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec = '0;
        bad = 1'b0;
        case (instr.r_view.opcode)
            OP_LUI: begin
                dec.ctl.b_sel   = 1'b1;
                dec.ctl.alu_sel = ALU_PASS_B;
                dec.ctl.reg_wen = 1'b1;
                dec.ctl.imm_sel = IMM_U;
                dec.ctl.wb_sel  = WB_ALU;
            end
            OP_AUIPC: begin
                dec.ctl.a_sel   = 1'b1;
                dec.ctl.b_sel   = 1'b1;
                dec.ctl.alu_sel = ALU_ADD;
                dec.ctl.reg_wen = 1'b1;
                dec.ctl.imm_sel = IMM_U;
                dec.ctl.wb_sel  = WB_ALU;
            end
            OP_JAL: begin
                dec.ctl.a_sel   = 1'b1;
                dec.ctl.b_sel   = 1'b1;
                dec.ctl.alu_sel = ALU_ADD;
                dec.ctl.reg_wen = 1'b1;
                dec.ctl.imm_sel = IMM_J;
                dec.ctl.pc_sel  = 1'b1;
                dec.ctl.wb_sel  = WB_PC4;
            end
            OP_JALR: begin
                dec.ctl.b_sel   = 1'b1;
                dec.ctl.alu_sel = ALU_ADD;
                dec.ctl.reg_wen = 1'b1;
                dec.ctl.imm_sel = IMM_I;
                dec.ctl.pc_sel  = 1'b1;
                dec.ctl.wb_sel  = WB_PC4;
                bad             = (funct3 != 3'b000);
            end
            // Direction and compare mode come from the branch resolver
            OP_BRANCH: begin
                dec.ctl.alu_sel = ALU_ADD;
                dec.ctl.imm_sel = IMM_B;
                dec.is_branch   = 1'b1;
            end
            OP_LOAD: begin
                dec.ctl.b_sel   = 1'b1;
                dec.ctl.alu_sel = ALU_ADD;
                dec.ctl.reg_wen = 1'b1;
                dec.ctl.imm_sel = IMM_I;
                dec.ctl.wb_sel  = WB_MEM;
                bad = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
            end
            OP_STORE: begin
                dec.ctl.b_sel   = 1'b1;
                dec.ctl.alu_sel = ALU_ADD;
                dec.ctl.mem_wr  = 1'b1;
                dec.ctl.imm_sel = IMM_S;
                bad             = funct3[2] || (funct3 == 3'b011);
            end
            OP_IMM: begin
                dec.ctl.b_sel   = 1'b1;
                dec.ctl.alu_sel = alu_of(funct3, f7_alt, 1'b0);
                dec.ctl.reg_wen = 1'b1;
                dec.ctl.imm_sel = IMM_I;
                dec.ctl.wb_sel  = WB_ALU;
                // Shift amounts leave funct7 as the shift type
                if (funct3 == 3'b001) begin
                    bad = !f7_base;
                end else if (funct3 == 3'b101) begin
                    bad = !(f7_base || f7_alt);
                end
            end
            OP_REG: begin
                dec.ctl.alu_sel = alu_of(funct3, f7_alt, 1'b1);
                dec.ctl.reg_wen = 1'b1;
                dec.ctl.imm_sel = IMM_R;
                dec.ctl.wb_sel  = WB_ALU;
                bad = !(f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OP_FENCE: begin
                bad = (funct3 != 3'b000);
            end
            // Only ECALL and EBREAK are accepted
            OP_SYSTEM: begin
                bad = (funct3 != 3'b000) || (instr.i_view.rs1 != 5'd0) ||
                      (instr.i_view.rd != 5'd0) || (instr.i_view.imm12[11:1] != 11'd0);
            end
            default: begin
                bad = 1'b1;
            end
        endcase

        if (bad) begin
            dec         = '0;
            dec.illegal = 1'b1;
        end
    end

    // No decoded word writes both memory and the register file
    assert property (@(instr) !(dec.ctl.mem_wr && dec.ctl.reg_wen));

endmodule

`default_nettype wire

// ==== hw/branch_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_ctl_params.svh"

module branch_resolver (
    input  wire logic [`RV_F3_W-1:0] funct3,
    input  wire logic                br_eq,
    input  wire logic                br_lt,
    output rv_ctl_pkg::br_out_t      br
);
    import rv_ctl_pkg::*;

    always_comb begin
        br       = '0;
        br.f3_ok = 1'b1;
        case (funct3)
            3'b000: br.taken = br_eq;
            3'b001: br.taken = !br_eq;
            3'b100: br.taken = br_lt;
            3'b101: br.taken = !br_lt;
            3'b110: begin
                br.taken = br_lt;
                br.br_un = 1'b1;
            end
            3'b111: begin
                br.taken = !br_lt;
                br.br_un = 1'b1;
            end
            // 010 and 011 are reserved
            default: br.f3_ok = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/ctl_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctl_merge (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 in_valid,
    input  wire rv_ctl_pkg::dec_out_t dec,
    input  wire rv_ctl_pkg::br_out_t  br,
    output logic                      out_valid,
    output rv_ctl_pkg::ctl_word_t     ctl,
    output logic                      illegal
);
    import rv_ctl_pkg::*;

    ctl_word_t merged;
    logic      bad;

    always_comb begin
        merged = dec.ctl;
        if (dec.is_branch) begin
            merged.pc_sel = br.taken;
            merged.br_un  = br.br_un;
        end
        bad = dec.illegal || (dec.is_branch && !br.f3_ok);
        if (bad) begin
            merged = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            ctl       <= '0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= in_valid;
            // Hold the last word through idle cycles
            if (in_valid) begin
                ctl     <= merged;
                illegal <= bad;
            end
        end
    end

    // An illegal word never leaves with live control
    assert property (@(posedge clk) disable iff (!rst_n) illegal |-> (ctl == '0));

endmodule

`default_nettype wire

// ==== hw/instr_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_ctl (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               in_valid,
    input  wire rv_ctl_pkg::instr_u instr,
    input  wire logic               br_eq,
    input  wire logic               br_lt,
    output wire logic               out_valid,
    output wire rv_ctl_pkg::ctl_word_t ctl,
    output wire logic               illegal
);
    import rv_ctl_pkg::*;

    wire dec_out_t dec;
    wire br_out_t  br;

    op_decoder u_op_decoder (
        .instr (instr),
        .dec   (dec)
    );

    branch_resolver u_branch_resolver (
        .funct3 (instr.r_view.funct3),
        .br_eq  (br_eq),
        .br_lt  (br_lt),
        .br     (br)
    );

    ctl_merge u_ctl_merge (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .dec       (dec),
        .br        (br),
        .out_valid (out_valid),
        .ctl       (ctl),
        .illegal   (illegal)
    );

endmodule

`default_nettype wire

// ==== tb/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    ctl_word_t ctl;
    logic      illegal;
} exp_t;

// Expected control word straight from the RV32I encoding tables
function automatic exp_t ref_ctl(
    input logic [`RV_XLEN-1:0] word,
    input logic                eq,
    input logic                lt
);
    exp_t       e;
    alu_op_e    f3_alu [8];
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    logic       taken;

    f3_alu = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    e   = '0;
    opc = word[6:0];
    f3  = word[14:12];
    f7  = word[31:25];
    ok  = 1'b1;

    // Field order: a_sel b_sel alu mem_wr reg_wen imm br_un pc_sel wb
    case (opc)
        7'b0110111: e.ctl = '{1'b0, 1'b1, ALU_PASS_B, 1'b0, 1'b1, IMM_U, 1'b0, 1'b0, WB_ALU};
        7'b0010111: e.ctl = '{1'b1, 1'b1, ALU_ADD, 1'b0, 1'b1, IMM_U, 1'b0, 1'b0, WB_ALU};
        7'b1101111: e.ctl = '{1'b1, 1'b1, ALU_ADD, 1'b0, 1'b1, IMM_J, 1'b0, 1'b1, WB_PC4};
        7'b1100111: begin
            e.ctl = '{1'b0, 1'b1, ALU_ADD, 1'b0, 1'b1, IMM_I, 1'b0, 1'b1, WB_PC4};
            ok    = (f3 == 3'b000);
        end
        7'b1100011: begin
            // Bit 2 picks less-than over equal, bit 0 inverts the sense
            taken = f3[2] ? (lt ^ f3[0]) : (eq ^ f3[0]);
            e.ctl = '{1'b0, 1'b0, ALU_ADD, 1'b0, 1'b0, IMM_B, f3[2] & f3[1], taken, WB_MEM};
            ok    = !(f3 inside {3'b010, 3'b011});
        end
        7'b0000011: begin
            e.ctl = '{1'b0, 1'b1, ALU_ADD, 1'b0, 1'b1, IMM_I, 1'b0, 1'b0, WB_MEM};
            ok    = f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        end
        7'b0100011: begin
            e.ctl = '{1'b0, 1'b1, ALU_ADD, 1'b1, 1'b0, IMM_S, 1'b0, 1'b0, WB_MEM};
            ok    = f3 inside {3'b000, 3'b001, 3'b010};
        end
        7'b0010011: begin
            e.ctl = '{1'b0, 1'b1, f3_alu[f3], 1'b0, 1'b1, IMM_I, 1'b0, 1'b0, WB_ALU};
            if (f3 == 3'b101 && f7 == 7'h20) e.ctl.alu_sel = ALU_SRA;
            if (f3 == 3'b001) ok = (f7 == 7'h00);
            if (f3 == 3'b101) ok = (f7 == 7'h00) || (f7 == 7'h20);
        end
        7'b0110011: begin
            e.ctl = '{1'b0, 1'b0, f3_alu[f3], 1'b0, 1'b1, IMM_R, 1'b0, 1'b0, WB_ALU};
            if (f7 == 7'h20 && f3 == 3'b000) e.ctl.alu_sel = ALU_SUB;
            if (f7 == 7'h20 && f3 == 3'b101) e.ctl.alu_sel = ALU_SRA;
            ok = (f7 == 7'h00) || (f7 == 7'h20 && f3 inside {3'b000, 3'b101});
        end
        7'b0001111: ok = (f3 == 3'b000);
        // ECALL or EBREAK only, bit 20 tells them apart
        7'b1110011: ok = (word[31:7] == 25'h0) || (word[31:7] == 25'h2000);
        default:    ok = 1'b0;
    endcase

    if (!ok) begin
        e         = '0;
        e.illegal = 1'b1;
    end
    return e;
endfunction

`endif

// ==== tb/tb_instr_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_ctl_params.svh"

module tb_instr_ctl;
    import rv_ctl_pkg::*;

    `include "tb_ref_model.svh"

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    instr_u    instr;
    logic      br_eq;
    logic      br_lt;
    logic      out_valid;
    ctl_word_t ctl;
    logic      illegal;

    exp_t        exp_q[$];
    string       name_q[$];
    exp_t        got;
    string       got_name;
    logic        vld_d;
    int          seed;
    logic [31:0] r;
    logic [31:0] w;
    logic [6:0]  legal_opc [11];

    instr_ctl i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .br_eq     (br_eq),
        .br_lt     (br_lt),
        .out_valid (out_valid),
        .ctl       (ctl),
        .illegal   (illegal)
    );

    always #5 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [16:0] exp_v,
                                   input logic [16:0] act_v);
        stop_with_error($sformatf("Mismatch in %s: expected %05h, actual %05h",
                                  name, exp_v, act_v));
    endtask

    // Fixed register fields with f7 as the upper immediate bits
    function automatic logic [31:0] enc_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
    endfunction

    task automatic drive_word(input logic [31:0] word, input logic eq, input logic lt,
                              input string name);
        @(posedge clk);
        in_valid <= 1'b1;
        instr    <= word;
        br_eq    <= eq;
        br_lt    <= lt;
        exp_q.push_back(ref_ctl(word, eq, lt));
        name_q.push_back(name);
    endtask

    task automatic drive_idle(input logic [31:0] word);
        @(posedge clk);
        in_valid <= 1'b0;
        instr    <= word;
    endtask

    // Output side is sampled on the edge before the DUT updates
    always @(posedge clk) begin
        if (rst_n) begin
            assert (out_valid == vld_d) else report_mismatch("valid timing", vld_d, out_valid);
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    stop_with_error("Output word arrived with no word outstanding");
                end else begin
                    got      = exp_q.pop_front();
                    got_name = name_q.pop_front();
                    assert ({ctl, illegal} == got) else
                        report_mismatch(got_name, got, {ctl, illegal});
                end
            end
        end
        vld_d = rst_n && in_valid;
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        instr     = '0;
        br_eq     = 1'b0;
        br_lt     = 1'b0;
        vld_d     = 1'b0;
        seed      = 32'h84bbd680;
        legal_opc = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
                      OP_STORE, OP_IMM, OP_REG, OP_FENCE, OP_SYSTEM};

        repeat (2) @(posedge clk);
        // A word presented during reset must not come out
        in_valid <= 1'b1;
        instr    <= {20'h00100, 5'd1, OP_JAL};
        repeat (3) @(posedge clk);
        rst_n    <= 1'b1;
        in_valid <= 1'b0;
        @(posedge clk);
        assert ({out_valid, illegal, ctl.mem_wr, ctl.reg_wen, ctl.pc_sel} == 5'b0) else
            report_mismatch("reset state", 17'h0,
                            {12'h0, out_valid, illegal, ctl.mem_wr, ctl.reg_wen, ctl.pc_sel});

        // Every kept instruction, back to back
        drive_word({20'h12345, 5'd1, OP_LUI}, 1'b0, 1'b0, "lui");
        drive_word({20'habcde, 5'd2, OP_AUIPC}, 1'b0, 1'b0, "auipc");
        drive_word({20'h00100, 5'd1, OP_JAL}, 1'b0, 1'b0, "jal");
        drive_word(enc_word(7'h00, 3'b000, OP_JALR), 1'b0, 1'b0, "jalr");
        for (int f = 0; f < 8; f++) begin
            if (f inside {0, 1, 2, 4, 5}) drive_word(enc_word(7'h01, f[2:0], OP_LOAD), 0, 0, "load");
        end
        for (int f = 0; f < 3; f++) drive_word(enc_word(7'h7f, f[2:0], OP_STORE), 0, 0, "store");
        for (int f = 0; f < 8; f++) drive_word(enc_word(7'h00, f[2:0], OP_IMM), 0, 0, "op_imm");
        drive_word(enc_word(7'h20, 3'b101, OP_IMM), 1'b0, 1'b0, "srai");
        for (int f = 0; f < 8; f++) drive_word(enc_word(7'h00, f[2:0], OP_REG), 0, 0, "op");
        drive_word(enc_word(7'h20, 3'b000, OP_REG), 1'b0, 1'b0, "sub");
        drive_word(enc_word(7'h20, 3'b101, OP_REG), 1'b0, 1'b0, "sra");
        drive_word(32'h0ff0000f, 1'b0, 1'b0, "fence");
        drive_word(32'h00000073, 1'b0, 1'b0, "ecall");
        drive_word(32'h00100073, 1'b0, 1'b0, "ebreak");

        // Six branches against all four flag pairs
        for (int f = 0; f < 8; f++) begin
            if (!(f inside {2, 3})) begin
                for (int c = 0; c < 4; c++) begin
                    drive_word(enc_word(7'h00, f[2:0], OP_BRANCH), c[1], c[0], "branch");
                end
            end
        end

        drive_word(32'h0000007f, 1'b0, 1'b0, "illegal opcode");
        drive_word(enc_word(7'h00, 3'b010, OP_BRANCH), 1'b1, 1'b0, "illegal branch");
        drive_word(enc_word(7'h01, 3'b000, OP_REG), 1'b0, 1'b0, "illegal op funct7");
        drive_word({12'd2, 13'd0, OP_SYSTEM}, 1'b0, 1'b0, "illegal system");

        for (int n = 0; n < 300; n++) begin
            r = $random(seed);
            w = $random(seed);
            if (r[0]) w[6:0] = legal_opc[r[11:8] % 4'd11];
            if (r[3:2] == 2'b00) drive_idle(w);
            else drive_word(w, r[4], r[5], "random");
        end

        drive_idle('0);
        for (int k = 0; k < 10 && exp_q.size() != 0; k++) @(posedge clk);
        if (exp_q.size() != 0) begin
            stop_with_error("Timed out waiting for outstanding control words");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
+incdir+tb
hw/rv_ctl_pkg.sv
hw/op_decoder.sv
hw/branch_resolver.sv
hw/ctl_merge.sv
hw/instr_ctl.sv
tb/tb_instr_ctl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the instr_ctl testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_instr_ctl -f list.f -o sim_instr_ctl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_instr_ctl > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0
